/* design/ht_cfg.svh */
`ifndef HT_CFG_SVH
`define HT_CFG_SVH

// key and value pointer fields
`define HT_KEY_W  64
`define HT_SIZE_W 16
`define HT_ADDR_W 32

// bucket address into the line memory
`define HT_HASH_W 21

// one memory line is one bucket of four slots
`define HT_SLOTS  4
`define HT_SLOT_W (`HT_KEY_W + `HT_SIZE_W + `HT_ADDR_W)
`define HT_LINE_W (`HT_SLOTS * `HT_SLOT_W)

`endif

/* design/ht_pkg.sv */
`include "ht_cfg.svh"

package ht_pkg;

	typedef enum logic [1:0] {
		OP_IGNORE = 2'd0,
		OP_GET    = 2'd1,
		OP_SET    = 2'd2,
		OP_DEL    = 2'd3
	} ht_op_t;

	typedef enum logic [1:0] {
		ST_HIT  = 2'd0,
		ST_MISS = 2'd1,
		ST_FULL = 2'd2
	} ht_status_t;

	typedef struct packed {
		logic [`HT_SIZE_W-1:0] size;
		logic [`HT_ADDR_W-1:0] addr;
	} ht_ptr_t;

	// key in the low bits, pointer above it
	typedef struct packed {
		ht_ptr_t              ptr;
		logic [`HT_KEY_W-1:0] key;
	} ht_slot_t;

	typedef struct packed {
		ht_op_t                op;
		logic [`HT_KEY_W-1:0]  key;
		logic [`HT_HASH_W-1:0] hash1;
		logic [`HT_HASH_W-1:0] hash2;
		logic [`HT_SIZE_W-1:0] size;
	} ht_req_t;

	typedef struct packed {
		logic [`HT_KEY_W-1:0] key;
		ht_status_t           status;
		ht_ptr_t              ptr;
	} ht_resp_t;

endpackage

/* design/ht_ifs.sv */
`include "ht_cfg.svh"

// request and both lines, handed from reader to writer
interface bucket_if import ht_pkg::*; ();
	ht_req_t               req;
	logic [`HT_LINE_W-1:0] line1;
	logic [`HT_LINE_W-1:0] line2;
	ht_ptr_t               alloc;
	logic                  valid;
	logic                  done;

	modport source (output req, line1, line2, alloc, valid, input done);
	modport sink (input req, line1, line2, alloc, valid, output done);
endinterface

// one slot position of both buckets
interface slot_if import ht_pkg::*; ();
	logic [`HT_KEY_W-1:0] key;
	ht_op_t               op;
	ht_ptr_t              new_ptr;
	ht_slot_t             entry1;
	ht_slot_t             entry2;
	logic                 strobe;
	logic                 hit1;
	logic                 hit2;
	logic                 empty1;
	logic                 empty2;
	ht_slot_t             new1;
	ht_slot_t             new2;

	modport source (output key, op, new_ptr, entry1, entry2, strobe);
	modport sink (input key, op, new_ptr, entry1, entry2, strobe,
		output hit1, hit2, empty1, empty2, new1, new2);
	modport result (input hit1, hit2, empty1, empty2, new1, new2);
endinterface

/* design/stream_buf.sv */
module stream_buf #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_regd,
	input  T     in_data,
	input  logic in_valid,
	output logic in_ready,
	output T     out_data,
	output logic out_valid,
	input  logic out_ready
);

	T     skid_data;
	logic skid_valid;
	logic push;
	logic pop;
	logic load;

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;
	// output register is free at this edge
	assign load = !out_valid || pop;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			in_ready   <= 1'b0;
		end else if (load) begin
			out_valid  <= skid_valid || push;
			skid_valid <= 1'b0;
			in_ready   <= 1'b1;
		end else if (push) begin
			// output stalled, park the word in the skid entry
			skid_valid <= 1'b1;
			in_ready   <= 1'b0;
		end else begin
			in_ready <= !skid_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= skid_valid ? skid_data : in_data;
		end
		if (!load && push) begin
			skid_data <= in_data;
		end
	end

endmodule

/* design/bucket_reader.sv */
`include "ht_cfg.svh"

module bucket_reader import ht_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  ht_req_t               req,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  logic [`HT_ADDR_W-1:0] malloc_pointer,
	input  logic                  malloc_valid,
	output logic                  malloc_ready,
	output logic [`HT_HASH_W-1:0] rdcmd_addr,
	output logic                  rdcmd_valid,
	input  logic                  rdcmd_ready,
	input  logic [`HT_LINE_W-1:0] rd_data,
	input  logic                  rd_valid,
	output logic                  rd_ready,
	bucket_if.source              bkt,
	slot_if.source                slots [`HT_SLOTS]
);

	typedef enum logic [2:0] {
		R_IDLE, R_ALLOC, R_CMD1, R_CMD2, R_RD1, R_RD2, R_STROBE, R_WAIT
	} state_t;

	state_t                state;
	ht_req_t               req_q;
	ht_ptr_t               alloc_q;
	logic [`HT_LINE_W-1:0] line1_q;
	logic [`HT_LINE_W-1:0] line2_q;
	logic                  valid_q;

	// ----------------------------------------------------------------------
	// request sequencing
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state        <= R_IDLE;
			req_ready    <= 1'b0;
			malloc_ready <= 1'b0;
			valid_q      <= 1'b0;
		end else begin
			malloc_ready <= 1'b0;
			case (state)
				R_IDLE: begin
					if (req_valid && req_ready) begin
						req_ready <= 1'b0;
						if (req.op == OP_IGNORE) begin
							state <= R_STROBE;
						end else if (req.op == OP_SET) begin
							state <= R_ALLOC;
						end else begin
							state <= R_CMD1;
						end
					end else begin
						req_ready <= 1'b1;
					end
				end
				R_ALLOC: begin
					// single cycle ready pulse takes the pointer
					if (malloc_valid) begin
						malloc_ready <= 1'b1;
						state        <= R_CMD1;
					end
				end
				R_CMD1:   if (rdcmd_ready) state <= R_CMD2;
				R_CMD2:   if (rdcmd_ready) state <= R_RD1;
				R_RD1:    if (rd_valid) state <= R_RD2;
				R_RD2:    if (rd_valid) state <= R_STROBE;
				R_STROBE: begin
					valid_q <= 1'b1;
					state   <= R_WAIT;
				end
				R_WAIT: begin
					if (bkt.done) begin
						valid_q <= 1'b0;
						state   <= R_IDLE;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == R_IDLE && req_valid && req_ready) begin
			req_q <= req;
		end
		if (state == R_ALLOC && malloc_valid) begin
			alloc_q <= '{size: req_q.size, addr: malloc_pointer};
		end
		if (state == R_RD1 && rd_valid) begin
			line1_q <= rd_data;
		end
		if (state == R_RD2 && rd_valid) begin
			line2_q <= rd_data;
		end
	end

	assign rdcmd_valid = (state == R_CMD1) || (state == R_CMD2);
	assign rdcmd_addr  = (state == R_CMD2) ? req_q.hash2 : req_q.hash1;
	assign rd_ready    = (state == R_RD1) || (state == R_RD2);

	assign bkt.req   = req_q;
	assign bkt.line1 = line1_q;
	assign bkt.line2 = line2_q;
	assign bkt.alloc = alloc_q;
	assign bkt.valid = valid_q;

	// ----------------------------------------------------------------------
	// fan the slots of both lines out to the compare units
	for (genvar i = 0; i < `HT_SLOTS; i++) begin : g_slot
		assign slots[i].key     = req_q.key;
		assign slots[i].op      = req_q.op;
		assign slots[i].new_ptr = alloc_q;
		assign slots[i].entry1  = line1_q[i*`HT_SLOT_W +: `HT_SLOT_W];
		assign slots[i].entry2  = line2_q[i*`HT_SLOT_W +: `HT_SLOT_W];
		assign slots[i].strobe  = (state == R_STROBE);
	end

endmodule

/* design/slot_unit.sv */
`include "ht_cfg.svh"

module slot_unit import ht_pkg::*; (
	input  logic clk,
	input  logic rst_regd,
	slot_if.sink sl
);

	// entry after the request is applied to this slot
	function automatic ht_slot_t next_entry(input ht_slot_t old, input ht_op_t op,
			input logic [`HT_KEY_W-1:0] key, input ht_ptr_t ptr);
		ht_slot_t e;
		e = old;
		case (op)
			OP_SET: begin
				e.key = key;
				e.ptr = ptr;
			end
			OP_DEL: e.ptr = '0;
			default: e = old;
		endcase
		return e;
	endfunction

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			sl.hit1   <= 1'b0;
			sl.hit2   <= 1'b0;
			sl.empty1 <= 1'b0;
			sl.empty2 <= 1'b0;
		end else if (sl.strobe) begin
			// a zero key never matches, it marks a free slot
			sl.hit1   <= (sl.entry1.key == sl.key) && (sl.key != '0);
			sl.hit2   <= (sl.entry2.key == sl.key) && (sl.key != '0);
			sl.empty1 <= (sl.entry1.key == '0);
			sl.empty2 <= (sl.entry2.key == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (sl.strobe) begin
			sl.new1 <= next_entry(sl.entry1, sl.op, sl.key, sl.new_ptr);
			sl.new2 <= next_entry(sl.entry2, sl.op, sl.key, sl.new_ptr);
		end
	end

endmodule

/* design/bucket_writer.sv */
`include "ht_cfg.svh"

module bucket_writer import ht_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	bucket_if.sink                bkt,
	slot_if.result                slots [`HT_SLOTS],
	output logic [`HT_ADDR_W-1:0] free_pointer,
	output logic [`HT_SIZE_W-1:0] free_size,
	output logic                  free_valid,
	input  logic                  free_ready,
	output logic [`HT_HASH_W-1:0] wrcmd_addr,
	output logic                  wrcmd_valid,
	input  logic                  wrcmd_ready,
	output logic [`HT_LINE_W-1:0] wr_data,
	output logic                  wr_valid,
	input  logic                  wr_ready,
	output ht_resp_t              resp,
	output logic                  resp_valid,
	input  logic                  resp_ready
);

	localparam int IDX_W = $clog2(`HT_SLOTS);

	typedef enum logic [1:0] {W_IDLE, W_ISSUE, W_RESP, W_DONE} state_t;

	state_t                state;
	logic [`HT_SLOTS-1:0]  hit1;
	logic [`HT_SLOTS-1:0]  hit2;
	logic [`HT_SLOTS-1:0]  empty1;
	logic [`HT_SLOTS-1:0]  empty2;
	ht_slot_t              new1 [`HT_SLOTS];
	ht_slot_t              new2 [`HT_SLOTS];
	logic                  sel_hit;
	logic                  found;
	logic                  sel_b2;
	logic [IDX_W-1:0]      sel_idx;
	logic [`HT_LINE_W-1:0] sel_line;
	logic [`HT_LINE_W-1:0] merged;
	ht_slot_t              old_e;
	ht_slot_t              new_e;
	logic                  need_write;
	logic                  need_free;
	ht_ptr_t               free_ptr;
	ht_resp_t              resp_d;

	for (genvar i = 0; i < `HT_SLOTS; i++) begin : g_gather
		assign hit1[i]   = slots[i].hit1;
		assign hit2[i]   = slots[i].hit2;
		assign empty1[i] = slots[i].empty1;
		assign empty2[i] = slots[i].empty2;
		assign new1[i]   = slots[i].new1;
		assign new2[i]   = slots[i].new2;
	end

	// ----------------------------------------------------------------------
	// slot choice: hit in bucket 1, hit in bucket 2, then empty for SET
	always_comb begin
		sel_hit = 1'b0;
		sel_b2  = 1'b0;
		sel_idx = '0;
		// scanning downward lets the lowest slot win
		for (int i = `HT_SLOTS-1; i >= 0; i--) begin
			if (hit2[i]) begin
				sel_hit = 1'b1;
				sel_b2  = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
		for (int i = `HT_SLOTS-1; i >= 0; i--) begin
			if (hit1[i]) begin
				sel_hit = 1'b1;
				sel_b2  = 1'b0;
				sel_idx = IDX_W'(i);
			end
		end
		found = sel_hit;
		if (!sel_hit && bkt.req.op == OP_SET) begin
			for (int i = `HT_SLOTS-1; i >= 0; i--) begin
				if (empty2[i]) begin
					found   = 1'b1;
					sel_b2  = 1'b1;
					sel_idx = IDX_W'(i);
				end
			end
			for (int i = `HT_SLOTS-1; i >= 0; i--) begin
				if (empty1[i]) begin
					found   = 1'b1;
					sel_b2  = 1'b0;
					sel_idx = IDX_W'(i);
				end
			end
		end
	end

	assign sel_line = sel_b2 ? bkt.line2 : bkt.line1;
	assign old_e    = sel_line[sel_idx*`HT_SLOT_W +: `HT_SLOT_W];
	assign new_e    = sel_b2 ? new2[sel_idx] : new1[sel_idx];

	always_comb begin
		merged = sel_line;
		merged[sel_idx*`HT_SLOT_W +: `HT_SLOT_W] = new_e;
	end

	always_comb begin
		need_write    = 1'b0;
		need_free     = 1'b0;
		free_ptr      = old_e.ptr;
		resp_d.key    = bkt.req.key;
		resp_d.status = ST_MISS;
		resp_d.ptr    = '0;
		case (bkt.req.op)
			OP_GET: begin
				if (sel_hit) begin
					resp_d.status = ST_HIT;
					resp_d.ptr    = old_e.ptr;
				end
			end
			OP_SET: begin
				if (found) begin
					need_write    = 1'b1;
					need_free     = sel_hit && (old_e.ptr != '0);
					resp_d.status = sel_hit ? ST_HIT : ST_MISS;
					resp_d.ptr    = bkt.alloc;
				end else begin
					// no room in either bucket, hand the allocation back
					need_free     = 1'b1;
					free_ptr      = bkt.alloc;
					resp_d.status = ST_FULL;
				end
			end
			OP_DEL: begin
				if (sel_hit) begin
					need_write    = 1'b1;
					need_free     = (old_e.ptr != '0);
					resp_d.status = ST_HIT;
					resp_d.ptr    = old_e.ptr;
				end
			end
			default: resp_d.status = ST_MISS;
		endcase
	end

	// ----------------------------------------------------------------------
	// issue free and write together, then the response
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state       <= W_IDLE;
			free_valid  <= 1'b0;
			wrcmd_valid <= 1'b0;
			wr_valid    <= 1'b0;
			resp_valid  <= 1'b0;
		end else begin
			case (state)
				W_IDLE: begin
					if (bkt.valid) begin
						free_valid  <= need_free;
						wrcmd_valid <= need_write;
						wr_valid    <= need_write;
						state       <= W_ISSUE;
					end
				end
				W_ISSUE: begin
					if (free_ready) free_valid <= 1'b0;
					if (wrcmd_ready) wrcmd_valid <= 1'b0;
					if (wr_ready) wr_valid <= 1'b0;
					if (!free_valid && !wrcmd_valid && !wr_valid) begin
						resp_valid <= 1'b1;
						state      <= W_RESP;
					end
				end
				W_RESP: begin
					if (resp_ready) begin
						resp_valid <= 1'b0;
						state      <= W_DONE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == W_IDLE && bkt.valid) begin
			free_pointer <= free_ptr.addr;
			free_size    <= free_ptr.size;
			wrcmd_addr   <= sel_b2 ? bkt.req.hash2 : bkt.req.hash1;
			wr_data      <= merged;
			resp         <= resp_d;
		end
	end

	assign bkt.done = (state == W_DONE);

endmodule

/* design/ht_update.sv */
`include "ht_cfg.svh"

module ht_update import ht_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  ht_op_t                req_op,
	input  logic [`HT_KEY_W-1:0]  req_key,
	input  logic [`HT_HASH_W-1:0] req_hash1,
	input  logic [`HT_HASH_W-1:0] req_hash2,
	input  logic [`HT_SIZE_W-1:0] req_size,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  logic [`HT_ADDR_W-1:0] malloc_pointer,
	input  logic                  malloc_valid,
	output logic                  malloc_ready,
	output logic [`HT_ADDR_W-1:0] free_pointer,
	output logic [`HT_SIZE_W-1:0] free_size,
	output logic                  free_valid,
	input  logic                  free_ready,
	output logic [`HT_HASH_W-1:0] rdcmd_addr,
	output logic                  rdcmd_valid,
	input  logic                  rdcmd_ready,
	input  logic [`HT_LINE_W-1:0] rd_data,
	input  logic                  rd_valid,
	output logic                  rd_ready,
	output logic [`HT_HASH_W-1:0] wrcmd_addr,
	output logic                  wrcmd_valid,
	input  logic                  wrcmd_ready,
	output logic [`HT_LINE_W-1:0] wr_data,
	output logic                  wr_valid,
	input  logic                  wr_ready,
	output logic [`HT_KEY_W-1:0]  resp_key,
	output ht_status_t            resp_status,
	output logic [`HT_SIZE_W-1:0] resp_size,
	output logic [`HT_ADDR_W-1:0] resp_pointer,
	output logic                  resp_valid,
	input  logic                  resp_ready
);

	ht_req_t  req_in;
	ht_req_t  req_q;
	logic     req_q_valid;
	logic     req_q_ready;
	ht_resp_t resp_d;
	ht_resp_t resp_q;
	logic     resp_d_valid;
	logic     resp_d_ready;

	bucket_if bkt_if ();
	slot_if   sl_if [`HT_SLOTS] ();

	assign req_in = '{op: req_op, key: req_key, hash1: req_hash1, hash2: req_hash2,
		size: req_size};

	assign resp_key     = resp_q.key;
	assign resp_status  = resp_q.status;
	assign resp_size    = resp_q.ptr.size;
	assign resp_pointer = resp_q.ptr.addr;

	stream_buf #(.T(ht_req_t)) req_buf (
		.clk       (clk),
		.rst_regd  (rst_regd),
		.in_data   (req_in),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.out_data  (req_q),
		.out_valid (req_q_valid),
		.out_ready (req_q_ready)
	);

	bucket_reader u_reader (
		.clk            (clk),
		.rst_regd       (rst_regd),
		.req            (req_q),
		.req_valid      (req_q_valid),
		.req_ready      (req_q_ready),
		.malloc_pointer (malloc_pointer),
		.malloc_valid   (malloc_valid),
		.malloc_ready   (malloc_ready),
		.rdcmd_addr     (rdcmd_addr),
		.rdcmd_valid    (rdcmd_valid),
		.rdcmd_ready    (rdcmd_ready),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid),
		.rd_ready       (rd_ready),
		.bkt            (bkt_if),
		.slots          (sl_if)
	);

	for (genvar i = 0; i < `HT_SLOTS; i++) begin : g_slot
		slot_unit u_slot (
			.clk      (clk),
			.rst_regd (rst_regd),
			.sl       (sl_if[i])
		);
	end

	bucket_writer u_writer (
		.clk          (clk),
		.rst_regd     (rst_regd),
		.bkt          (bkt_if),
		.slots        (sl_if),
		.free_pointer (free_pointer),
		.free_size    (free_size),
		.free_valid   (free_valid),
		.free_ready   (free_ready),
		.wrcmd_addr   (wrcmd_addr),
		.wrcmd_valid  (wrcmd_valid),
		.wrcmd_ready  (wrcmd_ready),
		.wr_data      (wr_data),
		.wr_valid     (wr_valid),
		.wr_ready     (wr_ready),
		.resp         (resp_d),
		.resp_valid   (resp_d_valid),
		.resp_ready   (resp_d_ready)
	);

	stream_buf #(.T(ht_resp_t)) resp_buf (
		.clk       (clk),
		.rst_regd  (rst_regd),
		.in_data   (resp_d),
		.in_valid  (resp_d_valid),
		.in_ready  (resp_d_ready),
		.out_data  (resp_q),
		.out_valid (resp_valid),
		.out_ready (resp_ready)
	);

endmodule

/* sim/ht_update_props.sv */
`include "ht_cfg.svh"

module ht_update_props import ht_pkg::*; (
	input logic                  clk,
	input logic                  rst_regd,
	input logic                  resp_valid,
	input logic                  resp_ready,
	input logic [`HT_KEY_W-1:0]  resp_key,
	input ht_status_t            resp_status,
	input logic [`HT_SIZE_W-1:0] resp_size,
	input logic [`HT_ADDR_W-1:0] resp_pointer,
	input logic                  wr_valid,
	input logic                  wrcmd_valid,
	input logic                  free_valid,
	input logic                  free_ready
);

	int fail_count;

	// response held while stalled
	a_resp_hold: assert property (@(posedge clk) disable iff (rst_regd)
		resp_valid && !resp_ready |=> resp_valid
			&& $stable({resp_key, resp_status, resp_size, resp_pointer}))
		else begin
			$error("response changed while stalled");
			fail_count++;
		end

	// write command and write data start together
	a_wr_pair: assert property (@(posedge clk) disable iff (rst_regd)
		$rose(wr_valid) == $rose(wrcmd_valid))
		else begin
			$error("write command and write data rose apart");
			fail_count++;
		end

	a_free_hold: assert property (@(posedge clk) disable iff (rst_regd)
		free_valid && !free_ready |=> free_valid)
		else begin
			$error("free valid dropped before ready");
			fail_count++;
		end

endmodule

bind ht_update ht_update_props u_props (.*);

/* sim/ht_checker.sv */
`include "ht_cfg.svh"

module ht_checker import ht_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  ht_op_t                req_op,
	input  logic [`HT_KEY_W-1:0]  req_key,
	input  logic [`HT_HASH_W-1:0] req_hash1,
	input  logic [`HT_HASH_W-1:0] req_hash2,
	input  logic [`HT_SIZE_W-1:0] req_size,
	input  logic                  req_valid,
	input  logic                  req_ready,
	input  logic [`HT_ADDR_W-1:0] malloc_pointer,
	input  logic                  malloc_valid,
	input  logic                  malloc_ready,
	input  logic [`HT_HASH_W-1:0] rdcmd_addr,
	input  logic                  rdcmd_valid,
	input  logic                  rdcmd_ready,
	input  logic [`HT_ADDR_W-1:0] free_pointer,
	input  logic [`HT_SIZE_W-1:0] free_size,
	input  logic                  free_valid,
	input  logic                  free_ready,
	input  logic [`HT_HASH_W-1:0] wrcmd_addr,
	input  logic                  wrcmd_valid,
	input  logic                  wrcmd_ready,
	input  logic [`HT_LINE_W-1:0] wr_data,
	input  logic                  wr_valid,
	input  logic                  wr_ready,
	input  logic [`HT_KEY_W-1:0]  resp_key,
	input  ht_status_t            resp_status,
	input  logic [`HT_SIZE_W-1:0] resp_size,
	input  logic [`HT_ADDR_W-1:0] resp_pointer,
	input  logic                  resp_valid,
	input  logic                  resp_ready,
	output int                    errors,
	output int                    n_resp,
	output int                    outstanding
);

	localparam int PTR_W = `HT_SIZE_W + `HT_ADDR_W;

	logic [`HT_LINE_W-1:0] shadow [8];
	ht_req_t               pend [$];
	logic [`HT_ADDR_W-1:0] allocs [$];
	logic [`HT_HASH_W-1:0] exp_ra [$];
	logic [`HT_KEY_W-1:0]  exp_rkey [$];
	logic [1:0]            exp_rst [$];
	logic [PTR_W-1:0]      exp_rptr [$];
	logic [PTR_W-1:0]      exp_free [$];
	logic [`HT_HASH_W-1:0] exp_wa [$];
	logic [`HT_LINE_W-1:0] exp_wd [$];
	ht_req_t               r_in;
	ht_req_t               r_cur;
	logic [`HT_ADDR_W-1:0] a_cur;

	initial begin
		for (int i = 0; i < 8; i++) begin
			shadow[i] = '0;
		end
	end

	function automatic void expect_resp(input logic [`HT_KEY_W-1:0] key,
			input ht_status_t st, input logic [PTR_W-1:0] ptr);
		exp_rkey.push_back(key);
		exp_rst.push_back(st);
		exp_rptr.push_back(ptr);
	endfunction

	// slot is {size, addr, key}, slot i at bit i*HT_SLOT_W
	function automatic void expect_write(input logic [`HT_HASH_W-1:0] h, input int i,
			input logic [`HT_KEY_W-1:0] key, input logic [PTR_W-1:0] ptr);
		logic [`HT_LINE_W-1:0] line;
		line = shadow[h[2:0]];
		line[i*`HT_SLOT_W +: `HT_SLOT_W] = {ptr, key};
		shadow[h[2:0]] = line;
		exp_wa.push_back(h);
		exp_wd.push_back(line);
	endfunction

	// ----------------------------------------------------------------------
	// reference model of one request on the shadow table
	function automatic void predict(input ht_req_t r, input logic [`HT_ADDR_W-1:0] alloc);
		logic [`HT_SLOT_W-1:0] s;
		logic [`HT_HASH_W-1:0] h;
		logic [PTR_W-1:0]      oldp;
		logic [PTR_W-1:0]      newp;
		int                    hb;
		int                    hi;
		int                    eb;
		int                    ei;
		hb = -1;
		hi = 0;
		eb = -1;
		ei = 0;
		oldp = '0;
		newp = {r.size, alloc};
		// every op but IGNORE reads hash1 and then hash2
		if (r.op != OP_IGNORE) begin
			exp_ra.push_back(r.hash1);
			exp_ra.push_back(r.hash2);
		end
		for (int b = 0; b < 2; b++) begin
			h = b ? r.hash2 : r.hash1;
			for (int i = 0; i < `HT_SLOTS; i++) begin
				s = shadow[h[2:0]][i*`HT_SLOT_W +: `HT_SLOT_W];
				if (hb < 0 && r.key != '0 && s[`HT_KEY_W-1:0] == r.key) begin
					hb = b;
					hi = i;
					oldp = s[`HT_SLOT_W-1:`HT_KEY_W];
				end
				if (eb < 0 && s[`HT_KEY_W-1:0] == '0) begin
					eb = b;
					ei = i;
				end
			end
		end
		case (r.op)
			OP_GET: expect_resp(r.key, hb >= 0 ? ST_HIT : ST_MISS, hb >= 0 ? oldp : '0);
			OP_SET: begin
				if (hb >= 0) begin
					if (oldp != '0) exp_free.push_back(oldp);
					expect_write(hb ? r.hash2 : r.hash1, hi, r.key, newp);
					expect_resp(r.key, ST_HIT, newp);
				end else if (eb >= 0) begin
					expect_write(eb ? r.hash2 : r.hash1, ei, r.key, newp);
					expect_resp(r.key, ST_MISS, newp);
				end else begin
					exp_free.push_back(newp);
					expect_resp(r.key, ST_FULL, '0);
				end
			end
			OP_DEL: begin
				if (hb >= 0) begin
					if (oldp != '0) exp_free.push_back(oldp);
					expect_write(hb ? r.hash2 : r.hash1, hi, r.key, '0);
					expect_resp(r.key, ST_HIT, oldp);
				end else begin
					expect_resp(r.key, ST_MISS, '0);
				end
			end
			default: expect_resp(r.key, ST_MISS, '0);
		endcase
	endfunction

	function automatic void compare_field(input string name,
			input logic [`HT_LINE_W-1:0] exp, input logic [`HT_LINE_W-1:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endfunction

	function automatic void unexpected(input string what);
		$display("%s transfer seen with no predicted transfer left", what);
		errors++;
	endfunction

	// ----------------------------------------------------------------------
	// compare transfers against the predictions, in order
	always @(posedge clk) begin
		if (rst_regd) begin
			errors = 0;
			n_resp = 0;
		end else begin
			if (req_valid && req_ready) begin
				r_in = '{op: req_op, key: req_key, hash1: req_hash1, hash2: req_hash2,
					size: req_size};
				pend.push_back(r_in);
			end
			if (malloc_valid && malloc_ready) allocs.push_back(malloc_pointer);
			while (pend.size() > 0 && (pend[0].op != OP_SET || allocs.size() > 0)) begin
				r_cur = pend.pop_front();
				a_cur = (r_cur.op == OP_SET) ? allocs.pop_front() : '0;
				predict(r_cur, a_cur);
			end
			if (rdcmd_valid && rdcmd_ready) begin
				if (exp_ra.size() == 0) unexpected("read command");
				else compare_field("rdcmd_addr", exp_ra.pop_front(), rdcmd_addr);
			end
			if (free_valid && free_ready) begin
				if (exp_free.size() == 0) unexpected("free");
				else compare_field("free_pointer", exp_free.pop_front(),
					{free_size, free_pointer});
			end
			if (wrcmd_valid && wrcmd_ready) begin
				if (exp_wa.size() == 0) unexpected("write command");
				else compare_field("wrcmd_addr", exp_wa.pop_front(), wrcmd_addr);
			end
			if (wr_valid && wr_ready) begin
				if (exp_wd.size() == 0) unexpected("write data");
				else compare_field("wr_data", exp_wd.pop_front(), wr_data);
			end
			if (resp_valid && resp_ready) begin
				n_resp++;
				if (exp_rkey.size() == 0) begin
					unexpected("response");
				end else begin
					compare_field("resp_key", exp_rkey.pop_front(), resp_key);
					compare_field("resp_status", exp_rst.pop_front(), resp_status);
					compare_field("resp_pointer", exp_rptr.pop_front(),
						{resp_size, resp_pointer});
				end
			end
		end
		outstanding = pend.size() + allocs.size() + exp_ra.size() + exp_rkey.size()
			+ exp_free.size() + exp_wa.size() + exp_wd.size();
	end

endmodule

/* sim/tb_ht_update.sv */
`include "ht_cfg.svh"

module tb_ht_update import ht_pkg::*; ();

	localparam int LIMIT = 2000;

	logic                  clk;
	logic                  rst_regd;
	ht_op_t                req_op;
	logic [`HT_KEY_W-1:0]  req_key;
	logic [`HT_HASH_W-1:0] req_hash1;
	logic [`HT_HASH_W-1:0] req_hash2;
	logic [`HT_SIZE_W-1:0] req_size;
	logic                  req_valid;
	logic                  req_ready;
	logic [`HT_ADDR_W-1:0] malloc_pointer;
	logic                  malloc_valid;
	logic                  malloc_ready;
	logic [`HT_ADDR_W-1:0] free_pointer;
	logic [`HT_SIZE_W-1:0] free_size;
	logic                  free_valid;
	logic                  free_ready;
	logic [`HT_HASH_W-1:0] rdcmd_addr;
	logic                  rdcmd_valid;
	logic                  rdcmd_ready;
	logic [`HT_LINE_W-1:0] rd_data;
	logic                  rd_valid;
	logic                  rd_ready;
	logic [`HT_HASH_W-1:0] wrcmd_addr;
	logic                  wrcmd_valid;
	logic                  wrcmd_ready;
	logic [`HT_LINE_W-1:0] wr_data;
	logic                  wr_valid;
	logic                  wr_ready;
	logic [`HT_KEY_W-1:0]  resp_key;
	ht_status_t            resp_status;
	logic [`HT_SIZE_W-1:0] resp_size;
	logic [`HT_ADDR_W-1:0] resp_pointer;
	logic                  resp_valid;
	logic                  resp_ready;
	int                    errors;
	int                    n_resp;
	int                    outstanding;

	integer                seed;
	logic                  bp_on;
	int                    n_sent;
	int                    timer;
	logic [`HT_KEY_W-1:0]  k;
	logic [`HT_ADDR_W-1:0] next_ptr;
	logic                  took_rd;
	logic                  took_mal;
	logic [`HT_LINE_W-1:0] mem [8];
	logic [`HT_HASH_W-1:0] rd_q [$];
	logic [`HT_HASH_W-1:0] wa_q [$];
	logic [`HT_LINE_W-1:0] wd_q [$];

	ht_update UUT (.*);

	ht_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	// one request, held until the DUT takes it
	task automatic send_req(input ht_op_t op, input logic [`HT_KEY_W-1:0] key,
			input logic [`HT_HASH_W-1:0] h1, input logic [`HT_HASH_W-1:0] h2, input int gap);
		int t;
		repeat (gap) @(posedge clk);
		#2;
		req_op    = op;
		req_key   = key;
		req_hash1 = h1;
		req_hash2 = h2;
		req_size  = 16'h0040 + key[7:0];
		req_valid = 1'b1;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > LIMIT) give_up("request ready");
		end while (!req_ready);
		#2;
		req_valid = 1'b0;
		n_sent++;
	endtask

	// ----------------------------------------------------------------------
	// memory model, allocator and ready generation
	always begin
		@(posedge clk);
		took_rd  = 1'b0;
		took_mal = 1'b0;
		if (!rst_regd) begin
			if (rdcmd_valid && rdcmd_ready) rd_q.push_back(rdcmd_addr);
			if (rd_valid && rd_ready) begin
				void'(rd_q.pop_front());
				took_rd = 1'b1;
			end
			if (wrcmd_valid && wrcmd_ready) wa_q.push_back(wrcmd_addr);
			if (wr_valid && wr_ready) wd_q.push_back(wr_data);
			while (wa_q.size() > 0 && wd_q.size() > 0) begin
				mem[wa_q.pop_front() & 7] = wd_q.pop_front();
			end
			if (malloc_valid && malloc_ready) begin
				next_ptr++;
				took_mal = 1'b1;
			end
		end
		#2;
		if (!rst_regd) begin
			if (took_rd) rd_valid = 1'b0;
			if (!rd_valid && rd_q.size() > 0 && (!bp_on || ($random(seed) & 3) != 0)) begin
				rd_valid = 1'b1;
				rd_data  = mem[rd_q[0] & 7];
			end
			if (took_mal) malloc_valid = 1'b0;
			if (!malloc_valid && (!bp_on || ($random(seed) & 1))) begin
				malloc_valid   = 1'b1;
				malloc_pointer = next_ptr;
			end
			rdcmd_ready = !bp_on || (($random(seed) & 3) != 0);
			free_ready  = !bp_on || (($random(seed) & 3) != 0);
			wrcmd_ready = !bp_on || (($random(seed) & 3) != 0);
			wr_ready    = !bp_on || (($random(seed) & 3) != 0);
			resp_ready  = !bp_on || (($random(seed) & 3) != 0);
		end
	end

	initial begin
		seed = 32'h5ad4_2468;
		bp_on = 1'b0;
		n_sent = 0;
		next_ptr = 32'h0000_0100;
		for (int i = 0; i < 8; i++) begin
			mem[i] = '0;
		end
		req_op = OP_IGNORE;
		req_key = '0;
		req_hash1 = '0;
		req_hash2 = '0;
		req_size = '0;
		req_valid = 1'b0;
		malloc_pointer = '0;
		malloc_valid = 1'b0;
		free_ready = 1'b0;
		rdcmd_ready = 1'b0;
		rd_data = '0;
		rd_valid = 1'b0;
		wrcmd_ready = 1'b0;
		wr_ready = 1'b0;
		resp_ready = 1'b0;
		rst_regd = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst_regd = 1'b0;

		// directed: set, get, overwrite, delete, miss, ignore
		send_req(OP_SET, 64'h11, 1, 2, 0);
		send_req(OP_GET, 64'h11, 1, 2, 0);
		send_req(OP_SET, 64'h11, 1, 2, 0);
		send_req(OP_DEL, 64'h11, 1, 2, 0);
		send_req(OP_GET, 64'h11, 1, 2, 0);
		send_req(OP_GET, 64'h99, 1, 2, 0);
		send_req(OP_DEL, 64'h98, 5, 6, 0);
		send_req(OP_IGNORE, 64'h77, 0, 0, 0);
		// fill both buckets 3 and 4, the ninth set finds no room
		for (int i = 0; i < 9; i++) begin
			send_req(OP_SET, 64'h200 + i, 3, 4, 0);
		end
		send_req(OP_GET, 64'h207, 3, 4, 0);

		// random traffic under back-pressure
		bp_on = 1'b1;
		for (int n = 0; n < 200; n++) begin
			k = 64'h1000 + ($random(seed) & 15) + 1;
			send_req(ht_op_t'($random(seed) & 3), k, `HT_HASH_W'((k * 3) & 7),
				`HT_HASH_W'((k * 5 + 1) & 7), $random(seed) & 3);
		end

		timer = 0;
		while (n_resp < n_sent || outstanding != 0) begin
			@(posedge clk);
			timer++;
			if (timer > 20 * LIMIT) give_up("the last responses");
		end
		repeat (4) @(posedge clk);

		$display("requests %0d, responses %0d, errors %0d, assert fails %0d, left over %0d",
			n_sent, n_resp, errors, UUT.u_props.fail_count, outstanding);
		if (errors == 0 && UUT.u_props.fail_count == 0 && outstanding == 0
				&& n_resp == n_sent) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+design
design/ht_pkg.sv
design/ht_ifs.sv
design/stream_buf.sv
design/bucket_reader.sv
design/slot_unit.sv
design/bucket_writer.sv
design/ht_update.sv
sim/ht_update_props.sv
sim/ht_checker.sv
sim/tb_ht_update.sv

/* Bender.yml */
package:
  name: ht_update

sources:
  - include_dirs:
      - design
    files:
      - design/ht_pkg.sv
      - design/ht_ifs.sv
      - design/stream_buf.sv
      - design/bucket_reader.sv
      - design/slot_unit.sv
      - design/bucket_writer.sv
      - design/ht_update.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/ht_update_props.sv
      - sim/ht_checker.sv
      - sim/tb_ht_update.sv
